// File: src.f
+incdir+hdl
hdl/sfilt_pkg.sv
hdl/sfilt_decode.sv
hdl/sfilt_mult.sv
hdl/sfilt_execute.sv
hdl/sfilt_result.sv
hdl/sfilt_top.sv
sim/sfilt_tb.sv

// File: sim/sfilt_tb.sv
// self-checking testbench for sfilt_top, stops at the first mismatch
// expects pushout three edges after the sampling edge, as with SFILT_MULT_STAGES = 2
`timescale 1ns/1ns
`default_nettype none

`include "sfilt_consts.svh"

module sfilt_tb;
	import sfilt_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	// driven at a negedge, sampled one edge later, seen three edges after that
	localparam int PUSH_DELAY = 4;
	localparam int MAX_CMDS = 400;
	localparam int MAX_GAP = 3;
	localparam int TESTS = 6;
	localparam int DRAIN_CYCLES = 10;
	localparam int WATCHDOG_CYCLES =
		RESET_CYCLES + MAX_CMDS * (MAX_GAP + 1) + TESTS * DRAIN_CYCLES + 50;

	logic CLK = 1'b0;
	logic rst;
	logic pushin;
	sfilt_cmd_e cmd;
	sample_t q;
	sample_t h;
	logic pushout;
	sample_t z;

	int unsigned cycle = 0;
	acc_t model_acc;
	sample_t exp_z[$];
	int unsigned exp_due[$];
	string test_name = "reset";

	sfilt_top UUT (
		.CLK(CLK), .rst(rst), .pushin(pushin), .cmd(cmd), .q(q), .h(h),
		.pushout(pushout), .z(z)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	always @(posedge CLK) begin
		cycle <= cycle + 1;
	end

	task automatic stop_with_failure();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic report_mismatch(string what, logic [63:0] expv, logic [63:0] actv);
		$display("** Error %s %s expected %0h actual %0h", test_name, what, expv, actv);
		stop_with_failure();
	endtask

	task automatic report_problem(string msg);
		$display("%s", msg);
		stop_with_failure();
	endtask

	// rounded arithmetic shift, straight from the arithmetic rules
	function automatic acc_t shift_round_ref(acc_t a, int s);
		acc_t res;
		logic rb;
		if (s == 0) begin
			return a;
		end
		if (s >= 64) begin
			res = {64{a[63]}};
		end else begin
			res = a >>> s;
		end
		if (s > 64) begin
			rb = a[63];
		end else begin
			rb = a[s-1];
		end
		return res + {63'd0, rb};
	endfunction

	task automatic model_step(sfilt_cmd_e c, sample_t qv, sample_t hv);
		acc_t qx;
		acc_t hx;
		acc_t prod;
		qx = qv;
		hx = hv;
		prod = qx * hx;
		case (c)
			cmd_load: model_acc = prod;
			cmd_mac: model_acc = model_acc + prod;
			cmd_shift: model_acc = shift_round_ref(model_acc, int'(hv[`SFILT_SHIFT_W-1:0]));
			default: begin
				exp_z.push_back(model_acc[31:0]);
				exp_due.push_back(cycle + PUSH_DELAY);
				model_acc = '0;
			end
		endcase
	endtask

	function automatic sample_t rand_word();
		return $urandom;
	endfunction

	// random upper bits, shift amount in the low bits
	function automatic sample_t shift_word(int s);
		sample_t w;
		w = $urandom;
		w[`SFILT_SHIFT_W-1:0] = s[`SFILT_SHIFT_W-1:0];
		return w;
	endfunction

	task automatic issue(sfilt_cmd_e c, sample_t qv, sample_t hv);
		@(negedge CLK);
		pushin = 1'b1;
		cmd = c;
		q = qv;
		h = hv;
		model_step(c, qv, hv);
	endtask

	// pushin low, junk on the other inputs
	task automatic idle_cycles(int n);
		repeat (n) begin
			@(negedge CLK);
			pushin = 1'b0;
			cmd = sfilt_cmd_e'($urandom_range(0, 3));
			q = rand_word();
			h = rand_word();
		end
	endtask

	task automatic random_gap();
		idle_cycles($urandom_range(0, MAX_GAP));
	endtask

	task automatic drain();
		idle_cycles(1);
		while (exp_z.size() > 0) begin
			idle_cycles(1);
		end
	endtask

	task automatic check_reset_idle();
		test_name = "reset_idle";
		for (int i = 0; i < 12; i++) begin
			idle_cycles(1);
			assert (z == '0) else report_mismatch("z before first send", 0, z);
		end
		issue(cmd_send, rand_word(), rand_word());
		issue(cmd_load, 32'sd5, -32'sd7);
		idle_cycles(6);
		issue(cmd_send, rand_word(), rand_word());
		drain();
	endtask

	task automatic load_then_send();
		test_name = "load_send";
		for (int i = 0; i < 8; i++) begin
			issue(cmd_load, rand_word(), rand_word());
			random_gap();
			issue(cmd_send, rand_word(), rand_word());
			random_gap();
		end
		drain();
	endtask

	task automatic mac_runs();
		int n;
		test_name = "mac_chain";
		for (int r = 0; r < 4; r++) begin
			issue(cmd_load, rand_word(), rand_word());
			n = $urandom_range(1, 20);
			repeat (n) issue(cmd_mac, rand_word(), rand_word());
			// odd rounds expose the upper word
			if (r % 2 == 1) begin
				issue(cmd_shift, rand_word(), shift_word(32));
			end
			issue(cmd_send, rand_word(), rand_word());
			random_gap();
		end
		// six products of 2^62 wrap past 2^63
		issue(cmd_load, 32'sh8000_0000, 32'sh8000_0000);
		repeat (5) issue(cmd_mac, 32'sh8000_0000, 32'sh8000_0000);
		issue(cmd_shift, rand_word(), shift_word(32));
		issue(cmd_send, rand_word(), rand_word());
		drain();
	endtask

	task automatic shift_rounding();
		int amounts[$];
		sample_t qv;
		sample_t hv;
		test_name = "shift_round";
		amounts = '{0, 1, 2, 31, 63, 64, 65, 100, 127};
		repeat (8) amounts.push_back($urandom_range(1, 64));
		for (int k = 0; k < amounts.size(); k++) begin
			qv = (rand_word() & 32'h7fff_ffff) | 32'h1;
			hv = (rand_word() & 32'h7fff_ffff) | 32'h1;
			// odd entries start from a negative accumulator
			if (k % 2 == 1) begin
				hv = -hv;
			end
			issue(cmd_load, qv, hv);
			issue(cmd_shift, rand_word(), shift_word(amounts[k]));
			issue(cmd_send, rand_word(), rand_word());
			random_gap();
		end
		drain();
	endtask

	task automatic send_clears_acc();
		test_name = "send_clears";
		for (int r = 0; r < 3; r++) begin
			issue(cmd_load, rand_word(), rand_word());
			issue(cmd_mac, rand_word(), rand_word());
			issue(cmd_send, rand_word(), rand_word());
			issue(cmd_send, rand_word(), rand_word());
			issue(cmd_mac, rand_word(), rand_word());
			issue(cmd_send, rand_word(), rand_word());
		end
		drain();
	endtask

	task automatic dense_mix();
		test_name = "dense_random";
		for (int i = 0; i < 180; i++) begin
			issue(sfilt_cmd_e'($urandom_range(0, 3)), rand_word(), rand_word());
			if ($urandom_range(0, 1) == 1) begin
				random_gap();
			end
		end
		drain();
	endtask

	// pushout against the expected queue, in order and at the fixed latency
	always @(negedge CLK) begin
		if (!rst) begin
			if (pushout) begin
				if (exp_z.size() == 0) begin
					report_problem($sformatf("pushout in %s with no send outstanding",
						test_name));
				end else begin
					assert (exp_due[0] == cycle)
						else report_mismatch("pushout cycle", exp_due[0], cycle);
					assert (z == exp_z[0]) else report_mismatch("z", exp_z[0], z);
					void'(exp_z.pop_front());
					void'(exp_due.pop_front());
				end
			end else if (exp_z.size() > 0) begin
				assert (exp_due[0] > cycle)
					else report_problem($sformatf("missing pushout in %s", test_name));
			end
		end
	end

	a_z_with_push: assert property (
		@(posedge CLK) disable iff (rst)
		!$stable(z) |-> pushout
	) else report_problem("z changed without a pushout");

	a_out_known: assert property (
		@(posedge CLK) disable iff (rst)
		!$isunknown({pushout, z})
	) else report_problem("pushout or z unknown after reset");

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		report_problem("watchdog timeout, the run did not finish in time");
	end

	initial begin
		void'($urandom(60));
		rst = 1'b1;
		pushin = 1'b0;
		cmd = cmd_load;
		q = '0;
		h = '0;
		model_acc = '0;
		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		rst = 1'b0;
		check_reset_idle();
		load_then_send();
		mac_runs();
		shift_rounding();
		send_clears_acc();
		dense_mix();
		if (exp_z.size() != 0) begin
			report_problem("sends still outstanding at the end of the run");
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: hdl/sfilt_top.sv
// filter cell top, decode -> execute -> result
// command sampled at edge k updates acc at edge k+3, no back-pressure
`timescale 1ns/1ns
`default_nettype none

`include "sfilt_consts.svh"

module sfilt_top (
	input logic CLK,
	input logic rst,
	input logic pushin,
	input sfilt_pkg::sfilt_cmd_e cmd,
	input sfilt_pkg::sample_t q,
	input sfilt_pkg::sample_t h,
	output logic pushout,
	output sfilt_pkg::sample_t z
);
	import sfilt_pkg::*;

	sample_t q_reg;
	sample_t h_reg;
	logic [`SFILT_SHIFT_W-1:0] shamt;
	logic op_load;
	logic op_mac;
	logic op_shift;
	logic op_send;
	acc_t acc;
	acc_t acc_next;
	logic acc_we;
	logic send_now;

	sfilt_decode u_decode (
		.CLK(CLK), .rst(rst), .pushin(pushin), .cmd(cmd), .q(q), .h(h),
		.q_reg(q_reg), .h_reg(h_reg), .shamt(shamt),
		.op_load(op_load), .op_mac(op_mac), .op_shift(op_shift), .op_send(op_send)
	);

	sfilt_execute u_execute (
		.CLK(CLK), .rst(rst), .q_reg(q_reg), .h_reg(h_reg), .shamt(shamt),
		.op_load(op_load), .op_mac(op_mac), .op_shift(op_shift), .op_send(op_send),
		.acc(acc), .acc_next(acc_next), .acc_we(acc_we), .send_now(send_now)
	);

	// acc loops back into execute
	sfilt_result u_result (
		.CLK(CLK), .rst(rst), .acc_we(acc_we), .send_now(send_now),
		.acc_next(acc_next), .acc(acc), .z(z), .pushout(pushout)
	);

endmodule

`default_nettype wire

// File: hdl/sfilt_result.sv
// accumulator and output register
// send wins over write, the two never arrive together
`timescale 1ns/1ns
`default_nettype none

`include "sfilt_consts.svh"

module sfilt_result (
	input logic CLK,
	input logic rst,
	input logic acc_we,
	input logic send_now,
	input sfilt_pkg::acc_t acc_next,
	output sfilt_pkg::acc_t acc,
	output sfilt_pkg::sample_t z,
	output logic pushout
);
	import sfilt_pkg::*;

	sample_t acc_low;

	// z only carries the low word, upper bits are dropped
	assign acc_low = acc[`SFILT_DATA_W-1:0];

	always_ff @(posedge CLK) begin
		if (rst) begin
			acc <= '0;
		end else if (send_now) begin
			acc <= '0;
		end else if (acc_we) begin
			acc <= acc_next;
		end
	end

	// z holds until the next send
	always_ff @(posedge CLK) begin
		if (rst) begin
			z <= '0;
			pushout <= 1'b0;
		end else begin
			pushout <= send_now;
			if (send_now) begin
				z <= acc_low;
			end
		end
	end

	// back-to-back pushout only for back-to-back sends
	a_pushout_pulse: assert property (
		@(posedge CLK) disable iff (rst)
		(pushout && $past(pushout)) |-> ($past(send_now) && $past(send_now, 2))
	) else $error("pushout held without two sends");

endmodule

`default_nettype wire

// File: hdl/sfilt_execute.sv
// next-accumulator logic, ops delayed to line up with the multiplier output
// reads acc combinationally, so a dependent command right behind needs no forwarding
`timescale 1ns/1ns
`default_nettype none

`include "sfilt_consts.svh"

module sfilt_execute (
	input logic CLK,
	input logic rst,
	input sfilt_pkg::sample_t q_reg,
	input sfilt_pkg::sample_t h_reg,
	input logic [`SFILT_SHIFT_W-1:0] shamt,
	input logic op_load,
	input logic op_mac,
	input logic op_shift,
	input logic op_send,
	input sfilt_pkg::acc_t acc,
	output sfilt_pkg::acc_t acc_next,
	output logic acc_we,
	output logic send_now
);
	import sfilt_pkg::*;

	localparam int STAGES = `SFILT_MULT_STAGES;

	acc_t product;
	logic [3:0] op_pipe [STAGES];
	logic [`SFILT_SHIFT_W-1:0] sh_pipe [STAGES];
	logic al_load;
	logic al_mac;
	logic al_shift;
	logic al_send;
	logic [`SFILT_SHIFT_W-1:0] al_shamt;
	logic signed [`SFILT_ACC_W:0] shift_ext;
	acc_t shifted;
	logic round_bit;

	sfilt_mult #(
		.A_W(`SFILT_DATA_W),
		.B_W(`SFILT_DATA_W)
	) u_mult (
		.CLK(CLK),
		.a(q_reg),
		.b(h_reg),
		.product(product)
	);

	// op delay line, same depth as the multiplier
	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < STAGES; i++) begin
				op_pipe[i] <= '0;
			end
		end else begin
			op_pipe[0] <= {op_send, op_shift, op_mac, op_load};
			for (int i = 1; i < STAGES; i++) begin
				op_pipe[i] <= op_pipe[i-1];
			end
		end
	end

	// shift amount travels with its op
	always_ff @(posedge CLK) begin
		sh_pipe[0] <= shamt;
		for (int i = 1; i < STAGES; i++) begin
			sh_pipe[i] <= sh_pipe[i-1];
		end
	end

	assign {al_send, al_shift, al_mac, al_load} = op_pipe[STAGES-1];
	assign al_shamt = sh_pipe[STAGES-1];

	// one guard bit below acc catches the last bit shifted out
	// s = 0 leaves it 0, s > 64 fills it with the sign
	assign shift_ext = $signed({acc, 1'b0}) >>> al_shamt;
	assign shifted = shift_ext[`SFILT_ACC_W:1];
	assign round_bit = shift_ext[0];

	always_comb begin
		acc_next = acc;
		if (al_load) begin
			acc_next = product;
		end else if (al_mac) begin
			acc_next = acc + product;
		end else if (al_shift) begin
			acc_next = shifted + acc_t'(round_bit);
		end
	end

	assign acc_we = al_load || al_mac || al_shift;
	assign send_now = al_send;

	// write and send must never collide in the result block
	a_we_send_excl: assert property (
		@(posedge CLK) disable iff (rst)
		!(acc_we && send_now)
	) else $error("acc_we and send_now both high");

endmodule

`default_nettype wire

// File: hdl/sfilt_mult.sv
// signed multiplier, product valid SFILT_MULT_STAGES cycles after a and b
// fully pipelined, no stall and no reset on the data path
`timescale 1ns/1ns
`default_nettype none

`include "sfilt_consts.svh"

module sfilt_mult #(
	parameter int A_W = 32,
	parameter int B_W = 32
) (
	input logic CLK,
	input logic signed [A_W-1:0] a,
	input logic signed [B_W-1:0] b,
	output logic signed [A_W+B_W-1:0] product
);
	localparam int P_W = A_W + B_W;
	localparam int STAGES = `SFILT_MULT_STAGES;

	logic signed [P_W-1:0] full_prod;
	logic signed [P_W-1:0] prod_pipe [STAGES];

	// both operands signed, so they extend to P_W before the multiply
	assign full_prod = a * b;

	// first stage takes the raw product, later stages retime it
	always_ff @(posedge CLK) begin
		prod_pipe[0] <= full_prod;
		for (int i = 1; i < STAGES; i++) begin
			prod_pipe[i] <= prod_pipe[i-1];
		end
	end

	assign product = prod_pipe[STAGES-1];

endmodule

`default_nettype wire

// File: hdl/sfilt_decode.sv
// input stage: cmd, q and h only matter in a cycle with pushin high
// held q and h stay put between strobes
`timescale 1ns/1ns
`default_nettype none

`include "sfilt_consts.svh"

module sfilt_decode (
	input logic CLK,
	input logic rst,
	input logic pushin,
	input sfilt_pkg::sfilt_cmd_e cmd,
	input sfilt_pkg::sample_t q,
	input sfilt_pkg::sample_t h,
	output sfilt_pkg::sample_t q_reg,
	output sfilt_pkg::sample_t h_reg,
	output logic [`SFILT_SHIFT_W-1:0] shamt,
	output logic op_load,
	output logic op_mac,
	output logic op_shift,
	output logic op_send
);
	import sfilt_pkg::*;

	// operand capture
	always_ff @(posedge CLK) begin
		if (rst) begin
			q_reg <= '0;
			h_reg <= '0;
		end else if (pushin) begin
			q_reg <= q;
			h_reg <= h;
		end
	end

	// shift amount rides along with the held h
	assign shamt = h_reg[`SFILT_SHIFT_W-1:0];

	// one-hot decode, qualified by the strobe
	always_ff @(posedge CLK) begin
		if (rst) begin
			op_load  <= 1'b0;
			op_mac   <= 1'b0;
			op_shift <= 1'b0;
			op_send  <= 1'b0;
		end else begin
			op_load  <= pushin && (cmd == cmd_load);
			op_mac   <= pushin && (cmd == cmd_mac);
			op_shift <= pushin && (cmd == cmd_shift);
			op_send  <= pushin && (cmd == cmd_send);
		end
	end

	// downstream select logic relies on at most one op per cycle
	a_op_onehot: assert property (
		@(posedge CLK) disable iff (rst)
		$onehot0({op_load, op_mac, op_shift, op_send})
	) else $error("decode op strobes not one-hot");

endmodule

`default_nettype wire

// File: hdl/sfilt_pkg.sv
// command encoding and datapath types for the filter cell
// all data is two's complement
`default_nettype none

`include "sfilt_consts.svh"

package sfilt_pkg;

	// encoding matches the 2-bit cmd port
	typedef enum logic [1:0] {
		cmd_load  = 2'd0,
		cmd_mac   = 2'd1,
		cmd_shift = 2'd2,
		cmd_send  = 2'd3
	} sfilt_cmd_e;

	// operand and output word
	typedef logic signed [`SFILT_DATA_W-1:0] sample_t;

	// accumulator, wraps modulo 2^64
	typedef logic signed [`SFILT_ACC_W-1:0] acc_t;

endpackage

`default_nettype wire

// File: hdl/sfilt_consts.svh
// widths and multiplier depth, shared by the RTL and the testbench
// SFILT_MULT_STAGES must be 1 or more
`ifndef SFILT_CONSTS_SVH
`define SFILT_CONSTS_SVH

// q, h and z
`define SFILT_DATA_W 32

// accumulator, holds a full product
`define SFILT_ACC_W 64

// shift amount, taken from h[6:0]
`define SFILT_SHIFT_W 7

// register stages inside the multiplier
// changing this moves the command-to-accumulator latency
`define SFILT_MULT_STAGES 2

`endif
